// File: sources.f
+incdir+hdl
+incdir+verif
hdl/lstm_fix_pkg.sv
hdl/lstm_cell_pkg.sv
hdl/lstm_ifs.sv
hdl/sigmoid_gate_bank.sv
hdl/candidate_gate.sv
hdl/cell_state_update.sv
hdl/lstm_cell_top.sv
verif/tb_lstm_cell.sv

// File: verif/lstm_ref_model.svh
// reference model of the LSTM cell, included inside the testbench module
// tables are rebuilt from exp at the segment midpoints, call build_tables first
// items must be evaluated in the order the DUT accepts them
`ifndef LSTM_REF_MODEL_SVH
`define LSTM_REF_MODEL_SVH

int                 sig_tab [32];
int                 tanh_tab [32];
lstm_fix_pkg::fix_t bias_ref [4][`LSTM_NEURONS]; // [gate code][neuron]
lstm_fix_pkg::fix_t c_ref [`LSTM_NEURONS];

function automatic void build_tables();
  real x;
  real e2;
  for (int s = -16; s < 16; s++) begin
    x  = (8.0 * s + 4.0) / 32.0; // segment midpoint
    e2 = $exp(2.0 * x);
    sig_tab[s + 16]  = int'(32.0 / (1.0 + $exp(-x)));
    tanh_tab[s + 16] = int'(32.0 * (e2 - 1.0) / (e2 + 1.0));
  end
endfunction

function automatic void clear_model();
  for (int n = 0; n < `LSTM_NEURONS; n++) begin
    c_ref[n] = '0;
    for (int g = 0; g < 4; g++) begin
      bias_ref[g][n] = '0;
    end
  end
endfunction

function automatic int clamp_add(int a, int b);
  int s;
  s = a + b;
  if (s > 127) return 127;
  if (s < -128) return -128;
  return s;
endfunction

// sign and magnitude, magnitude truncated then clamped
function automatic int mul_sm(int a, int b);
  int p;
  p = ((a < 0) ? -a : a) * ((b < 0) ? -b : b) / 32;
  if (p > 127) p = 127;
  return ((a < 0) != (b < 0)) ? -p : p;
endfunction

function automatic int sigmoid_ref(int x);
  return sig_tab[(x >>> 3) + 16];
endfunction

function automatic int tanh_ref(int x);
  return tanh_tab[(x >>> 3) + 16];
endfunction

// m holds ix ih fx fh ox oh gx gh
function automatic void evaluate_item(input int n, input lstm_fix_pkg::fix_t m [8],
                                      output lstm_fix_pkg::fix_t h,
                                      output lstm_fix_pkg::fix_t c);
  int gi;
  int gf;
  int go;
  int gg;
  int c_new;
  gi    = sigmoid_ref(clamp_add(clamp_add(m[0], m[1]), bias_ref[0][n]));
  gf    = sigmoid_ref(clamp_add(clamp_add(m[2], m[3]), bias_ref[1][n]));
  go    = sigmoid_ref(clamp_add(clamp_add(m[4], m[5]), bias_ref[2][n]));
  gg    = tanh_ref(clamp_add(clamp_add(m[6], m[7]), bias_ref[3][n]));
  c_new = clamp_add(mul_sm(gf, c_ref[n]), mul_sm(gi, gg));
  c_ref[n] = lstm_fix_pkg::fix_t'(c_new);
  c = c_ref[n];
  h = lstm_fix_pkg::fix_t'(mul_sm(go, tanh_ref(c_new)));
endfunction

`endif

// File: verif/tb_lstm_cell.sv
// randomized testbench for lstm_cell_top against the model in lstm_ref_model.svh
// inputs change 1 ns after the rising edge and outputs are sampled on the falling edge
`timescale 1ns/1ps
`include "lstm_cfg.svh"

module tb_lstm_cell;

  logic                   clk;
  logic                   rst_i;
  logic                   seq_start_i;
  logic                   bias_we_i;
  lstm_cell_pkg::gate_e   bias_gate_i;
  lstm_cell_pkg::neuron_t bias_neuron_i;
  lstm_fix_pkg::fix_t     bias_data_i;
  logic                   valid_i;
  lstm_cell_pkg::neuron_t neuron_i;
  lstm_fix_pkg::fix_t     mac_ix_i, mac_ih_i, mac_fx_i, mac_fh_i;
  lstm_fix_pkg::fix_t     mac_ox_i, mac_oh_i, mac_gx_i, mac_gh_i;
  logic                   h_valid_o;
  lstm_cell_pkg::neuron_t h_neuron_o;
  lstm_fix_pkg::fix_t     h_o;
  lstm_fix_pkg::fix_t     c_o;

  lstm_fix_pkg::fix_t     mac_v [8]; // ix ih fx fh ox oh gx gh
  int                     cycle_cnt = 0;
  int                     errors = 0;
  int                     checked = 0;
  int                     exp_stamp_q [$];
  lstm_cell_pkg::neuron_t exp_neuron_q [$];
  lstm_fix_pkg::fix_t     exp_h_q [$];
  lstm_fix_pkg::fix_t     exp_c_q [$];

  `include "lstm_ref_model.svh"

  lstm_cell_top i_lstm_cell_top (
    .clk (clk), .rst_i (rst_i), .seq_start_i (seq_start_i),
    .bias_we_i (bias_we_i), .bias_gate_i (bias_gate_i),
    .bias_neuron_i (bias_neuron_i), .bias_data_i (bias_data_i),
    .valid_i (valid_i), .neuron_i (neuron_i),
    .mac_ix_i (mac_ix_i), .mac_ih_i (mac_ih_i), .mac_fx_i (mac_fx_i), .mac_fh_i (mac_fh_i),
    .mac_ox_i (mac_ox_i), .mac_oh_i (mac_oh_i), .mac_gx_i (mac_gx_i), .mac_gh_i (mac_gh_i),
    .h_valid_o (h_valid_o), .h_neuron_o (h_neuron_o), .h_o (h_o), .c_o (c_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk; // 8 ns period
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  //////////////////////////////
  // stimulus tasks
  //////////////////////////////
  task automatic set_idle();
    seq_start_i = 1'b0;
    bias_we_i   = 1'b0;
    valid_i     = 1'b0;
  endtask

  task automatic idle_for(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      set_idle();
    end
  endtask

  task automatic write_bias(input lstm_cell_pkg::gate_e g, input lstm_cell_pkg::neuron_t n,
                            input lstm_fix_pkg::fix_t d);
    @(posedge clk);
    #1;
    set_idle();
    bias_we_i     = 1'b1;
    bias_gate_i   = g;
    bias_neuron_i = n;
    bias_data_i   = d;
    bias_ref[int'(g)][n] = d;
  endtask

  task automatic send_item(input lstm_cell_pkg::neuron_t n);
    lstm_fix_pkg::fix_t h_exp;
    lstm_fix_pkg::fix_t c_exp;
    @(posedge clk);
    #1;
    set_idle();
    valid_i  = 1'b1;
    neuron_i = n;
    mac_ix_i = mac_v[0];
    mac_ih_i = mac_v[1];
    mac_fx_i = mac_v[2];
    mac_fh_i = mac_v[3];
    mac_ox_i = mac_v[4];
    mac_oh_i = mac_v[5];
    mac_gx_i = mac_v[6];
    mac_gh_i = mac_v[7];
    evaluate_item(n, mac_v, h_exp, c_exp);
    exp_stamp_q.push_back(cycle_cnt + 1); // sampled at the coming edge
    exp_neuron_q.push_back(n);
    exp_h_q.push_back(h_exp);
    exp_c_q.push_back(c_exp);
  endtask

  task automatic pulse_seq_start();
    @(posedge clk);
    #1;
    set_idle();
    seq_start_i = 1'b1;
    for (int n = 0; n < `LSTM_NEURONS; n++) begin
      c_ref[n] = '0;
    end
  endtask

  // waits for all results and then leaves the pipe quiet for bias writes
  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_stamp_q.size() > 0 && waited < 40) begin
      @(posedge clk);
      #1;
      set_idle();
      waited++;
    end
    if (exp_stamp_q.size() > 0) begin
      errors++;
      $display("timeout at %0t: %0d expected results never came out of the DUT",
               $time, exp_stamp_q.size());
      exp_stamp_q.delete();
      exp_neuron_q.delete();
      exp_h_q.delete();
      exp_c_q.delete();
    end
    idle_for(6);
  endtask

  function automatic void fill_random_macs();
    for (int k = 0; k < 8; k++) begin
      if ($urandom_range(1) == 1) mac_v[k] = lstm_fix_pkg::fix_t'($urandom);
      else mac_v[k] = lstm_fix_pkg::fix_t'(int'($urandom_range(32)) - 16); // near zero
    end
  endfunction

  function automatic void fill_extreme_macs();
    for (int k = 0; k < 8; k++) begin
      case ($urandom_range(2))
        0: mac_v[k] = 8'sd127;
        1: mac_v[k] = -8'sd127;
        default: mac_v[k] = lstm_fix_pkg::fix_t'(-128);
      endcase
    end
  endfunction

  //////////////////////////////
  // output checks
  //////////////////////////////
  always @(negedge clk) begin : check_outputs
    int lat;
    if (rst_i === 1'b0 && h_valid_o === 1'b1) begin
      if (exp_stamp_q.size() == 0) begin
        errors++;
        $display("unexpected h_valid_o pulse at %0t with no item in flight", $time);
      end else begin
        lat = cycle_cnt - exp_stamp_q.pop_front();
        checked++;
        if (lat != 5) begin
          errors++;
          $display("[ERROR] %0t latency expected 5 got %0d", $time, lat);
        end
        if (h_neuron_o !== exp_neuron_q[0]) begin
          errors++;
          $display("[ERROR] %0t h_neuron_o expected %0d got %0d",
                   $time, exp_neuron_q[0], h_neuron_o);
        end
        if (h_o !== exp_h_q[0]) begin
          errors++;
          $display("[ERROR] %0t h_o expected %0d got %0d", $time, exp_h_q[0], h_o);
        end
        if (c_o !== exp_c_q[0]) begin
          errors++;
          $display("[ERROR] %0t c_o expected %0d got %0d", $time, exp_c_q[0], c_o);
        end
        void'(exp_neuron_q.pop_front());
        void'(exp_h_q.pop_front());
        void'(exp_c_q.pop_front());
      end
    end
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////
  initial begin
    int gap;
    void'($urandom(94));
    rst_i         = 1'b1;
    seq_start_i   = 1'b0;
    bias_we_i     = 1'b0;
    bias_gate_i   = lstm_cell_pkg::GATE_I;
    bias_neuron_i = '0;
    bias_data_i   = '0;
    valid_i       = 1'b0;
    neuron_i      = '0;
    {mac_ix_i, mac_ih_i, mac_fx_i, mac_fh_i} = '0;
    {mac_ox_i, mac_oh_i, mac_gx_i, mac_gh_i} = '0;
    build_tables();
    clear_model();
    repeat (8) @(posedge clk);
    #1;
    rst_i = 1'b0;

    for (int k = 0; k < 20; k++) begin // quiet after reset
      @(posedge clk);
      #1;
      if (h_valid_o !== 1'b0) begin
        errors++;
        $display("[ERROR] %0t h_valid_o expected 0 got %b", $time, h_valid_o);
      end
    end

    for (int g = 0; g < 4; g++) begin
      for (int n = 0; n < `LSTM_NEURONS; n++) begin
        write_bias(lstm_cell_pkg::gate_e'(g), lstm_cell_pkg::neuron_t'(n),
                   lstm_fix_pkg::fix_t'($urandom));
      end
    end
    idle_for(6);

    repeat (32) begin // isolated items
      fill_random_macs();
      send_item(lstm_cell_pkg::neuron_t'($urandom_range(`LSTM_NEURONS - 1)));
      wait_drained();
    end

    repeat (3) begin // one neuron back to back
      for (int k = 0; k < 8; k++) begin
        fill_random_macs();
        send_item(lstm_cell_pkg::neuron_t'(5));
      end
      wait_drained();
    end

    repeat (24) begin // saturating inputs
      fill_extreme_macs();
      send_item(lstm_cell_pkg::neuron_t'($urandom_range(3)));
      if ($urandom_range(1) == 1) wait_drained();
    end
    wait_drained();

    pulse_seq_start();
    for (int n = 0; n < `LSTM_NEURONS; n++) begin
      fill_random_macs();
      send_item(lstm_cell_pkg::neuron_t'(n));
    end
    wait_drained();

    for (int k = 0; k < 2000; k++) begin // random stream
      fill_random_macs();
      send_item(lstm_cell_pkg::neuron_t'($urandom_range(`LSTM_NEURONS - 1)));
      gap = ($urandom_range(3) == 0) ? $urandom_range(4, 1) : 0;
      if (gap > 0) idle_for(gap);
    end
    wait_drained();

    $display("run finished: %0d results checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/lstm_cell_top.sv
// LSTM cell datapath, one item per cycle, h_valid_o five cycles after valid_i
// biases and seq_start_i only while nothing is in flight
// MAC results come in ready-made, neuron sequencing is up to the caller
`timescale 1ns/1ps

module lstm_cell_top (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   seq_start_i,
  input  logic                   bias_we_i,
  input  lstm_cell_pkg::gate_e   bias_gate_i,
  input  lstm_cell_pkg::neuron_t bias_neuron_i,
  input  lstm_fix_pkg::fix_t     bias_data_i,
  input  logic                   valid_i,
  input  lstm_cell_pkg::neuron_t neuron_i,
  input  lstm_fix_pkg::fix_t     mac_ix_i,
  input  lstm_fix_pkg::fix_t     mac_ih_i,
  input  lstm_fix_pkg::fix_t     mac_fx_i,
  input  lstm_fix_pkg::fix_t     mac_fh_i,
  input  lstm_fix_pkg::fix_t     mac_ox_i,
  input  lstm_fix_pkg::fix_t     mac_oh_i,
  input  lstm_fix_pkg::fix_t     mac_gx_i,
  input  lstm_fix_pkg::fix_t     mac_gh_i,
  output logic                   h_valid_o,
  output lstm_cell_pkg::neuron_t h_neuron_o,
  output lstm_fix_pkg::fix_t     h_o,
  output lstm_fix_pkg::fix_t     c_o
);

  bias_wr_if  i_bias_wr ();
  gate_act_if i_gate_act ();

  // bias write port onto the shared bus
  assign i_bias_wr.we     = bias_we_i;
  assign i_bias_wr.gate   = bias_gate_i;
  assign i_bias_wr.neuron = bias_neuron_i;
  assign i_bias_wr.data   = bias_data_i;

  sigmoid_gate_bank i_sigmoid_gate_bank (
    .clk      (clk),
    .rst_i    (rst_i),
    .bias     (i_bias_wr.rd_mp),
    .valid_i  (valid_i),
    .neuron_i (neuron_i),
    .mac_ix_i (mac_ix_i),
    .mac_ih_i (mac_ih_i),
    .mac_fx_i (mac_fx_i),
    .mac_fh_i (mac_fh_i),
    .mac_ox_i (mac_ox_i),
    .mac_oh_i (mac_oh_i),
    .act      (i_gate_act.sig_mp)
  );

  candidate_gate i_candidate_gate (
    .clk      (clk),
    .rst_i    (rst_i),
    .bias     (i_bias_wr.rd_mp),
    .neuron_i (neuron_i),
    .mac_gx_i (mac_gx_i),
    .mac_gh_i (mac_gh_i),
    .act      (i_gate_act.cand_mp)
  );

  cell_state_update i_cell_state_update (
    .clk         (clk),
    .rst_i       (rst_i),
    .seq_start_i (seq_start_i),
    .act         (i_gate_act.cell_mp),
    .h_valid_o   (h_valid_o),
    .h_neuron_o  (h_neuron_o),
    .h_o         (h_o),
    .c_o         (c_o)
  );

endmodule

// File: hdl/cell_state_update.sv
// cell-state update and output stage
// c_prev is read and written in the same stage, so back-to-back items chain
// seq_start_i clears every cell state and wins over a write in that cycle
`timescale 1ns/1ps
`include "lstm_cfg.svh"

module cell_state_update (
  input  logic                   clk,
  input  logic                   rst_i,
  input  logic                   seq_start_i,
  gate_act_if.cell_mp            act,
  output logic                   h_valid_o,
  output lstm_cell_pkg::neuron_t h_neuron_o,
  output lstm_fix_pkg::fix_t     h_o,
  output lstm_fix_pkg::fix_t     c_o
);

  lstm_fix_pkg::fix_t     c_mem [`LSTM_NEURONS];

  lstm_fix_pkg::fix_t     c_prev;
  lstm_fix_pkg::fix_t     f_term;
  lstm_fix_pkg::fix_t     i_term;
  lstm_fix_pkg::fix_t     c_new;

  logic                   valid_q3, valid_q4;
  lstm_cell_pkg::neuron_t neuron_q3, neuron_q4;
  lstm_fix_pkg::fix_t     c_q3, c_q4;
  lstm_fix_pkg::fix_t     o_q3, o_q4;
  lstm_fix_pkg::fix_t     tanh_q4;

  //////////////////////////////
  // new cell state
  //////////////////////////////
  assign c_prev = c_mem[act.neuron];
  assign f_term = lstm_fix_pkg::fix_mul(act.act_f, c_prev); // f * c_prev
  assign i_term = lstm_fix_pkg::fix_mul(act.act_i, act.act_g); // i * g
  assign c_new  = lstm_fix_pkg::sat_add(f_term, i_term);

  always_ff @(posedge clk) begin
    if (rst_i || seq_start_i) begin
      for (int n = 0; n < `LSTM_NEURONS; n++) begin
        c_mem[n] <= '0;
      end
    end else if (act.valid) begin
      c_mem[act.neuron] <= c_new;
    end
  end

  //////////////////////////////
  // output pipeline
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q3  <= 1'b0;
      valid_q4  <= 1'b0;
      h_valid_o <= 1'b0;
    end else begin
      valid_q3  <= act.valid;
      valid_q4  <= valid_q3;
      h_valid_o <= valid_q4;
    end
  end

  always_ff @(posedge clk) begin
    neuron_q3  <= act.neuron;
    c_q3       <= c_new;
    o_q3       <= act.act_o; // o rides along with c
    neuron_q4  <= neuron_q3;
    c_q4       <= c_q3;
    o_q4       <= o_q3;
    tanh_q4    <= lstm_fix_pkg::tanh_lut(c_q3);
    h_neuron_o <= neuron_q4;
    c_o        <= c_q4;
    h_o        <= lstm_fix_pkg::fix_mul(o_q4, tanh_q4); // h = o * tanh(c)
  end

endmodule

// File: hdl/candidate_gate.sv
// candidate gate: bias add then tanh
// same two-stage timing as sigmoid_gate_bank so act_g lines up with act.valid
`timescale 1ns/1ps
`include "lstm_cfg.svh"

module candidate_gate (
  input  logic                   clk,
  input  logic                   rst_i,
  bias_wr_if.rd_mp               bias,
  input  lstm_cell_pkg::neuron_t neuron_i,
  input  lstm_fix_pkg::fix_t     mac_gx_i,
  input  lstm_fix_pkg::fix_t     mac_gh_i,
  gate_act_if.cand_mp            act
);

  lstm_fix_pkg::fix_t     bias_g_mem [`LSTM_NEURONS];

  lstm_cell_pkg::neuron_t neuron_q0;
  lstm_fix_pkg::fix_t     gx_q0, gh_q0;
  lstm_fix_pkg::fix_t     sum_g_q1;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int n = 0; n < `LSTM_NEURONS; n++) begin
        bias_g_mem[n] <= '0;
      end
    end else if (bias.we && (bias.gate == lstm_cell_pkg::GATE_G)) begin
      bias_g_mem[bias.neuron] <= bias.data;
    end
  end

  // runs every cycle, valid travels in the sigmoid bank
  always_ff @(posedge clk) begin
    neuron_q0 <= neuron_i;
    gx_q0     <= mac_gx_i;
    gh_q0     <= mac_gh_i;
    sum_g_q1  <= lstm_fix_pkg::sat_add(lstm_fix_pkg::sat_add(gx_q0, gh_q0), bias_g_mem[neuron_q0]);
    act.act_g <= lstm_fix_pkg::tanh_lut(sum_g_q1);
  end

endmodule

// File: hdl/sigmoid_gate_bank.sv
// input, forget and output gates: bias add then sigmoid
// two cycles from the input register to act, no back-pressure
// a bias write racing an item for the same neuron gives an undefined mix
`timescale 1ns/1ps
`include "lstm_cfg.svh"

module sigmoid_gate_bank (
  input  logic                   clk,
  input  logic                   rst_i,
  bias_wr_if.rd_mp               bias,
  input  logic                   valid_i,
  input  lstm_cell_pkg::neuron_t neuron_i,
  input  lstm_fix_pkg::fix_t     mac_ix_i,
  input  lstm_fix_pkg::fix_t     mac_ih_i,
  input  lstm_fix_pkg::fix_t     mac_fx_i,
  input  lstm_fix_pkg::fix_t     mac_fh_i,
  input  lstm_fix_pkg::fix_t     mac_ox_i,
  input  lstm_fix_pkg::fix_t     mac_oh_i,
  gate_act_if.sig_mp             act
);

  lstm_fix_pkg::fix_t     bias_i_mem [`LSTM_NEURONS];
  lstm_fix_pkg::fix_t     bias_f_mem [`LSTM_NEURONS];
  lstm_fix_pkg::fix_t     bias_o_mem [`LSTM_NEURONS];

  logic                   valid_q0, valid_q1;
  lstm_cell_pkg::neuron_t neuron_q0, neuron_q1;
  lstm_fix_pkg::fix_t     ix_q0, ih_q0, fx_q0, fh_q0, ox_q0, oh_q0;
  lstm_fix_pkg::fix_t     sum_i_q1, sum_f_q1, sum_o_q1;

  //////////////////////////////
  // bias tables
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int n = 0; n < `LSTM_NEURONS; n++) begin
        bias_i_mem[n] <= '0;
        bias_f_mem[n] <= '0;
        bias_o_mem[n] <= '0;
      end
    end else if (bias.we) begin
      case (bias.gate)
        lstm_cell_pkg::GATE_I: bias_i_mem[bias.neuron] <= bias.data;
        lstm_cell_pkg::GATE_F: bias_f_mem[bias.neuron] <= bias.data;
        lstm_cell_pkg::GATE_O: bias_o_mem[bias.neuron] <= bias.data;
        default: ; // candidate bias lives in candidate_gate
      endcase
    end
  end

  //////////////////////////////
  // pipeline
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q0  <= 1'b0;
      valid_q1  <= 1'b0;
      act.valid <= 1'b0;
    end else begin
      valid_q0  <= valid_i;
      valid_q1  <= valid_q0;
      act.valid <= valid_q1;
    end
  end

  always_ff @(posedge clk) begin
    neuron_q0  <= neuron_i; // input register
    ix_q0      <= mac_ix_i;
    ih_q0      <= mac_ih_i;
    fx_q0      <= mac_fx_i;
    fh_q0      <= mac_fh_i;
    ox_q0      <= mac_ox_i;
    oh_q0      <= mac_oh_i;
    neuron_q1  <= neuron_q0; // pre-activation sums
    sum_i_q1   <= lstm_fix_pkg::sat_add(lstm_fix_pkg::sat_add(ix_q0, ih_q0), bias_i_mem[neuron_q0]);
    sum_f_q1   <= lstm_fix_pkg::sat_add(lstm_fix_pkg::sat_add(fx_q0, fh_q0), bias_f_mem[neuron_q0]);
    sum_o_q1   <= lstm_fix_pkg::sat_add(lstm_fix_pkg::sat_add(ox_q0, oh_q0), bias_o_mem[neuron_q0]);
    act.neuron <= neuron_q1; // activations
    act.act_i  <= lstm_fix_pkg::sigmoid_lut(sum_i_q1);
    act.act_f  <= lstm_fix_pkg::sigmoid_lut(sum_f_q1);
    act.act_o  <= lstm_fix_pkg::sigmoid_lut(sum_o_q1);
  end

endmodule

// File: hdl/lstm_ifs.sv
// internal buses of the LSTM cell
// bias_wr_if: one write per cycle, no handshake
// gate_act_if: valid is a plain strobe, act_g shares the sigmoid side's valid
`timescale 1ns/1ps

interface bias_wr_if;
  logic                   we;
  lstm_cell_pkg::gate_e   gate;
  lstm_cell_pkg::neuron_t neuron;
  lstm_fix_pkg::fix_t     data;

  modport wr_mp (output we, gate, neuron, data);
  modport rd_mp (input we, gate, neuron, data);
endinterface

interface gate_act_if;
  logic                   valid;
  lstm_cell_pkg::neuron_t neuron;
  lstm_fix_pkg::fix_t     act_i;
  lstm_fix_pkg::fix_t     act_f;
  lstm_fix_pkg::fix_t     act_o;
  lstm_fix_pkg::fix_t     act_g;

  // sigmoid bank owns the control fields
  modport sig_mp (output valid, neuron, act_i, act_f, act_o);
  modport cand_mp (output act_g);
  modport cell_mp (input valid, neuron, act_i, act_f, act_o, act_g);
endinterface

// File: hdl/lstm_cell_pkg.sv
// gate codes and neuron index for the LSTM cell
// gate code values are visible on the bias write port, keep them stable
`include "lstm_cfg.svh"

package lstm_cell_pkg;

  typedef enum logic [1:0] {
    GATE_I = 2'd0, // input gate
    GATE_F = 2'd1, // forget gate
    GATE_O = 2'd2, // output gate
    GATE_G = 2'd3  // candidate
  } gate_e;

  typedef logic [`LSTM_NEURON_W-1:0] neuron_t;

endpackage

// File: hdl/lstm_fix_pkg.sv
// signed fixed-point types and arithmetic for the LSTM datapath
// all results saturate to the data range, products truncate toward zero
// the two activation tables hold 32 segments each and are only valid for the default config
`include "lstm_cfg.svh"

package lstm_fix_pkg;

  typedef logic signed [`LSTM_DATA_W-1:0]   fix_t;
  typedef logic signed [2*`LSTM_DATA_W-1:0] prod_t;

  localparam fix_t FIX_MAX = {1'b0, {(`LSTM_DATA_W-1){1'b1}}};
  localparam fix_t FIX_MIN = {1'b1, {(`LSTM_DATA_W-1){1'b0}}};

  //////////////////////////////
  // arithmetic
  //////////////////////////////

  function automatic fix_t sat_add(fix_t a, fix_t b);
    logic signed [`LSTM_DATA_W:0] sum;
    sum = a + b; // one guard bit
    if (sum > FIX_MAX) return FIX_MAX;
    if (sum < FIX_MIN) return FIX_MIN;
    return sum[`LSTM_DATA_W-1:0];
  endfunction

  // sign and magnitude multiply, magnitude clamps at FIX_MAX
  function automatic fix_t fix_mul(fix_t a, fix_t b);
    logic [`LSTM_DATA_W-1:0] mag_a;
    logic [`LSTM_DATA_W-1:0] mag_b;
    prod_t                   prod;
    prod_t                   scaled;
    fix_t                    mag;
    logic                    neg;
    mag_a  = a[`LSTM_DATA_W-1] ? (~a + 1'b1) : a; // -128 maps to 128
    mag_b  = b[`LSTM_DATA_W-1] ? (~b + 1'b1) : b;
    neg    = a[`LSTM_DATA_W-1] ^ b[`LSTM_DATA_W-1];
    prod   = mag_a * mag_b;
    scaled = prod >>> `LSTM_FRAC_W; // always positive here
    mag    = (scaled > FIX_MAX) ? FIX_MAX : scaled[`LSTM_DATA_W-1:0];
    return neg ? -mag : mag;
  endfunction

  //////////////////////////////
  // activation tables
  //////////////////////////////

  // round(32 / (1 + exp(-(8s+4)/32))) per segment s
  function automatic fix_t sigmoid_lut(fix_t x);
    logic [`LSTM_DATA_W-`LSTM_LUT_SHIFT-1:0] seg;
    fix_t                                    y;
    seg = x[`LSTM_DATA_W-1:`LSTM_LUT_SHIFT];
    case (seg)
      5'd16: y = fix_t'(1);  // s = -16
      5'd17: y = fix_t'(1);
      5'd18: y = fix_t'(1);
      5'd19: y = fix_t'(1);
      5'd20: y = fix_t'(2);  // s = -12
      5'd21: y = fix_t'(2);
      5'd22: y = fix_t'(3);
      5'd23: y = fix_t'(3);
      5'd24: y = fix_t'(4);  // s = -8
      5'd25: y = fix_t'(5);
      5'd26: y = fix_t'(6);
      5'd27: y = fix_t'(8);
      5'd28: y = fix_t'(9);  // s = -4
      5'd29: y = fix_t'(11);
      5'd30: y = fix_t'(13);
      5'd31: y = fix_t'(15);
      5'd0:  y = fix_t'(17); // s = 0
      5'd1:  y = fix_t'(19);
      5'd2:  y = fix_t'(21);
      5'd3:  y = fix_t'(23);
      5'd4:  y = fix_t'(24); // s = 4
      5'd5:  y = fix_t'(26);
      5'd6:  y = fix_t'(27);
      5'd7:  y = fix_t'(28);
      5'd8:  y = fix_t'(29); // s = 8
      5'd9:  y = fix_t'(29);
      5'd10: y = fix_t'(30);
      5'd11: y = fix_t'(30);
      5'd12: y = fix_t'(31); // s = 12
      5'd13: y = fix_t'(31);
      5'd14: y = fix_t'(31);
      5'd15: y = fix_t'(31);
    endcase
    return y;
  endfunction

  // round(32 * tanh((8s+4)/32)), odd around the segment midpoints
  function automatic fix_t tanh_lut(fix_t x);
    logic [`LSTM_DATA_W-`LSTM_LUT_SHIFT-1:0] seg;
    fix_t                                    y;
    seg = x[`LSTM_DATA_W-1:`LSTM_LUT_SHIFT];
    case (seg)
      5'd16: y = fix_t'(-32); // s = -16
      5'd17: y = fix_t'(-32);
      5'd18: y = fix_t'(-32);
      5'd19: y = fix_t'(-32);
      5'd20: y = fix_t'(-32); // s = -12
      5'd21: y = fix_t'(-32);
      5'd22: y = fix_t'(-31);
      5'd23: y = fix_t'(-31);
      5'd24: y = fix_t'(-31); // s = -8
      5'd25: y = fix_t'(-30);
      5'd26: y = fix_t'(-28);
      5'd27: y = fix_t'(-26);
      5'd28: y = fix_t'(-23); // s = -4
      5'd29: y = fix_t'(-18);
      5'd30: y = fix_t'(-11);
      5'd31: y = fix_t'(-4);
      5'd0:  y = fix_t'(4);   // s = 0
      5'd1:  y = fix_t'(11);
      5'd2:  y = fix_t'(18);
      5'd3:  y = fix_t'(23);
      5'd4:  y = fix_t'(26);  // s = 4
      5'd5:  y = fix_t'(28);
      5'd6:  y = fix_t'(30);
      5'd7:  y = fix_t'(31);
      5'd8:  y = fix_t'(31);  // s = 8
      5'd9:  y = fix_t'(31);
      5'd10: y = fix_t'(32);
      5'd11: y = fix_t'(32);
      5'd12: y = fix_t'(32);  // s = 12
      5'd13: y = fix_t'(32);
      5'd14: y = fix_t'(32);
      5'd15: y = fix_t'(32);
    endcase
    return y;
  endfunction

endpackage

// File: hdl/lstm_cfg.svh
// sizing and fixed-point macros for the LSTM cell
// the sigmoid and tanh tables in lstm_fix_pkg assume 8-bit data, 5 fraction bits and shift 3
// LSTM_NEURON_W must be wide enough to index LSTM_NEURONS entries
`ifndef LSTM_CFG_SVH
`define LSTM_CFG_SVH

// data format
`define LSTM_DATA_W    8  // every data value, signed
`define LSTM_FRAC_W    5  // one lsb is 1/32

// neuron storage
`define LSTM_NEURONS   16 // bias and cell-state entries
`define LSTM_NEURON_W  4  // neuron index width

// activation tables
`define LSTM_LUT_SHIFT 3  // value >>> shift gives segment

`endif
